// ==== test/dp_cdc_golden.txt ====
# word (hex), consumer stall in di_clk cycles, sync_ctrl (0 sync_2, 1 sync_3, 2 sync_4)
# one transfer per line, words must arrive in this order
00000001 0 0
deadbeef 3 1
12345678 0 2
ffffffff 5 0
00000000 1 1
cafef00d 7 2
80000000 2 0
7fffffff 0 1
0f0f0f0f 4 2
a5a55a5a 9 0
13579bdf 1 1
2468ace0 6 2
55aa33cc 2 0
89abcdef 0 2

// ==== files.f ====
common/dp_cfg_pkg.sv
common/dp_cdc_pkg.sv
rtl/dp_sync.sv
dp_hs/dp_hs_req.sv
dp_hs/dp_hs_ack.sv
rtl/dp_src_if.sv
rtl/dp_cdc_port.sv
test/tb_dp_cdc_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CDC port testbench with Verilator
# Exit status is nonzero unless the log holds the pass message

set -u

cd "$(dirname "$0")" || exit 1

top=tb_dp_cdc_port
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module "$top" -f files.f -o "sim_$top"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"sim_$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^all tests passed$" "$log"; then
   exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== test/tb_dp_cdc_port.sv ====
/*
 * Testbench for the single-word CDC port
 * Replays the golden transfer list across two unrelated clocks and
 * checks word order, stall behavior and the return of si_ready
 */

`timescale 1ns/1ps
`default_nettype none

module tb_dp_cdc_port import dp_cfg_pkg::*; ();

   localparam int data_width = data_width_default;

   logic                  si_clk;
   logic                  di_clk;
   logic                  async_reset_n;
   logic                  si_sync_reset_n;
   logic                  di_sync_reset_n;
   sync_depth_t           sync_ctrl;
   logic                  si_valid;
   logic [data_width-1:0] si_data;
   logic                  si_ready;
   logic                  di_valid;
   logic [data_width-1:0] di_data;
   logic                  di_take;
   // Set by the consumer side once the current word is taken
   logic                  taken;

   dp_cdc_port #(
      .data_width (data_width)
   ) dut_i (
      .si_clk          (si_clk),
      .di_clk          (di_clk),
      .async_reset_n   (async_reset_n),
      .si_sync_reset_n (si_sync_reset_n),
      .di_sync_reset_n (di_sync_reset_n),
      .sync_ctrl       (sync_ctrl),
      .si_valid        (si_valid),
      .si_data         (si_data),
      .si_ready        (si_ready),
      .di_valid        (di_valid),
      .di_data         (di_data),
      .di_take         (di_take)
   );

   // Source period 4 ns and destination period 6 ns
   always #2 si_clk = ~si_clk;
   always #3 di_clk = ~di_clk;

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      $display("tests failed");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_word(input string name, input logic [data_width-1:0] expected,
                             input logic [data_width-1:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s expected %h actual %h", name, expected, actual);
         $display("tests failed");
         $fatal(1, "Simulation stopped");
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAIL %s expected %b actual %b", name, expected, actual);
         $display("tests failed");
         $fatal(1, "Simulation stopped");
      end
   endtask

   // Wait for both crossing wires high and let the synchronizer chains drain
   task automatic wait_quiet();
      int n;
      n = 0;
      while (!(dut_i.ai_req_n && dut_i.ai_ack_n)) begin
         @(posedge di_clk);
         #1;
         n++;
         if (n > 200) report_timeout("crossing wires never returned high");
      end
      repeat (6) @(posedge di_clk);
      @(posedge si_clk);
      #1;
   endtask

   task automatic run_source(input string name, input logic [data_width-1:0] word);
      int n;
      si_data  = word;
      si_valid = 1'b1;
      n = 0;
      // Idle port takes the word at the next edge
      do begin
         @(posedge si_clk);
         #1;
         n++;
         if (n > 200) report_timeout({name, ": word never accepted"});
      end while (si_ready);
      // Decoy stays offered while busy and must never get in
      si_data = ~word;
      n = 0;
      do begin
         @(posedge si_clk);
         #1;
         n++;
         if (n > 200) report_timeout({name, ": si_ready never returned"});
      end while (!si_ready);
      si_valid = 1'b0;
      si_data  = '0;
      check_flag({name, " taken before si_ready"}, 1'b1, taken);
   endtask

   task automatic run_sink(input string name, input logic [data_width-1:0] word,
                           input int stall);
      int n;
      n = 0;
      while (!di_valid) begin
         @(posedge di_clk);
         #1;
         n++;
         if (n > 200) report_timeout({name, ": di_valid never rose"});
      end
      check_word({name, " data"}, word, di_data);
      // Consumer holds off and the word must sit still
      for (int i = 0; i < stall; i++) begin
         @(posedge di_clk);
         #1;
         check_flag({name, " valid in stall"}, 1'b1, di_valid);
         check_word({name, " data in stall"}, word, di_data);
      end
      di_take = 1'b1;
      @(posedge di_clk);
      #1;
      di_take = 1'b0;
      taken   = 1'b1;
      check_flag({name, " valid after take"}, 1'b0, di_valid);
   endtask

   initial begin
      int                    fd;
      int                    rc;
      int                    stall;
      int                    code;
      int                    count;
      logic [data_width-1:0] word;
      logic [8*128-1:0]      header;
      si_clk          = 1'b0;
      di_clk          = 1'b0;
      async_reset_n   = 1'b0;
      si_sync_reset_n = 1'b0;
      di_sync_reset_n = 1'b0;
      sync_ctrl       = sync_2;
      si_valid        = 1'b0;
      si_data         = '0;
      di_take         = 1'b0;
      taken           = 1'b0;
      repeat (16) @(posedge si_clk);
      #1;
      async_reset_n   = 1'b1;
      si_sync_reset_n = 1'b1;
      di_sync_reset_n = 1'b1;
      repeat (4) @(posedge si_clk);
      #1;
      check_flag("reset si_ready", 1'b1, si_ready);
      check_flag("reset di_valid", 1'b0, di_valid);
      fd = $fopen("test/dp_cdc_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file test/dp_cdc_golden.txt");
         $display("tests failed");
         $fatal(1, "Simulation stopped");
      end
      // Two column description lines
      rc = $fgets(header, fd);
      rc = $fgets(header, fd);
      count = 0;
      rc = $fscanf(fd, "%h %d %d\n", word, stall, code);
      while (rc == 3) begin
         wait_quiet();
         // Depth changes only with the port idle
         sync_ctrl = sync_depth_t'(code[1:0]);
         taken     = 1'b0;
         fork
            run_source($sformatf("word %0d", count), word);
            run_sink($sformatf("word %0d", count), word, stall);
         join
         count++;
         rc = $fscanf(fd, "%h %d %d\n", word, stall, code);
      end
      $fclose(fd);
      wait_quiet();
      check_flag("no extra word", 1'b0, di_valid);
      check_flag("final si_ready", 1'b1, si_ready);
      if (count == 0) begin
         $display("The golden file holds no transfers");
         $display("tests failed");
         $fatal(1, "Simulation stopped");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule : tb_dp_cdc_port

`default_nettype wire

// ==== rtl/dp_cdc_port.sv ====
/*
 * Single-word CDC port
 * Source front end and request machine on si_clk,
 * acknowledge machine and word register on di_clk
 */

`timescale 1ns/1ps
`default_nettype none

module dp_cdc_port import dp_cfg_pkg::*; #(
   parameter int data_width = data_width_default
) (
   input  logic                  si_clk,
   input  logic                  di_clk,
   input  logic                  async_reset_n,
   input  logic                  si_sync_reset_n,
   input  logic                  di_sync_reset_n,
   input  sync_depth_t           sync_ctrl,
   input  logic                  si_valid,
   input  logic [data_width-1:0] si_data,
   output logic                  si_ready,
   output logic                  di_valid,
   output logic [data_width-1:0] di_data,
   input  logic                  di_take
);

   // Source-local handshake
   logic                  si_req_n;
   logic                  si_ack_n;
   // Crossing levels and the held word
   logic                  ai_req_n;
   logic                  ai_ack_n;
   logic [data_width-1:0] hold_data;

   dp_src_if #(
      .data_width (data_width)
   ) src_if_i (
      .async_reset_n (async_reset_n),
      .sync_reset_n  (si_sync_reset_n),
      .si_clk        (si_clk),
      .si_valid      (si_valid),
      .si_data       (si_data),
      .si_ready      (si_ready),
      .si_req_n      (si_req_n),
      .si_ack_n      (si_ack_n),
      .hold_data     (hold_data)
   );

   dp_hs_req hs_req_i (
      .async_reset_n (async_reset_n),
      .sync_reset_n  (si_sync_reset_n),
      .sync_ctrl     (sync_ctrl),
      .si_clk        (si_clk),
      .si_req_n      (si_req_n),
      .si_ack_n      (si_ack_n),
      .ai_req_n      (ai_req_n),
      .ai_ack_n      (ai_ack_n)
   );

   dp_hs_ack #(
      .data_width (data_width)
   ) hs_ack_i (
      .async_reset_n (async_reset_n),
      .sync_reset_n  (di_sync_reset_n),
      .sync_ctrl     (sync_ctrl),
      .di_clk        (di_clk),
      .ai_req_n      (ai_req_n),
      .ai_ack_n      (ai_ack_n),
      .hold_data     (hold_data),
      .di_valid      (di_valid),
      .di_data       (di_data),
      .di_take       (di_take)
   );

endmodule : dp_cdc_port

`default_nettype wire

// ==== rtl/dp_src_if.sv ====
/*
 * Source front end
 * Accepts one word, holds it and keeps the request low until acknowledged
 */

`timescale 1ns/1ps
`default_nettype none

module dp_src_if import dp_cfg_pkg::*, dp_cdc_pkg::*; #(
   parameter int data_width = data_width_default
) (
   input  logic                  async_reset_n,
   input  logic                  sync_reset_n,
   input  logic                  si_clk,
   input  logic                  si_valid,
   input  logic [data_width-1:0] si_data,
   output logic                  si_ready,
   output logic                  si_req_n,
   input  logic                  si_ack_n,
   output logic [data_width-1:0] hold_data
);

   src_state_t state_q;
   logic       accept;

   assign si_ready = (state_q == idle);
   assign accept   = si_valid && si_ready;

   always_ff @(posedge si_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         state_q  <= idle;
         si_req_n <= 1'b1;
      end else if (!sync_reset_n) begin
         state_q  <= idle;
         si_req_n <= 1'b1;
      end else if (accept) begin
         // Request goes low in the cycle after acceptance
         state_q  <= busy;
         si_req_n <= 1'b0;
      end else if (state_q == busy && !si_ack_n) begin
         // Ack pulse frees the port for the next word
         state_q  <= idle;
         si_req_n <= 1'b1;
      end
   end

   // Held word for the destination side
   always_ff @(posedge si_clk) begin
      if (accept) hold_data <= si_data;
   end

   // Far side samples hold_data any time during busy
   a_hold_stable: assert property (
      @(posedge si_clk) disable iff (!async_reset_n)
      (state_q == busy) |=> $stable(hold_data)
   ) else $error("hold_data changed while busy");

endmodule : dp_src_if

`default_nettype wire

// ==== dp_hs/dp_hs_ack.sv ====
/*
 * Acknowledge side of the four-phase handshake
 * Synchronizes the request, captures the held word, offers it to the
 * consumer and returns the ack only after the word is taken
 */

`timescale 1ns/1ps
`default_nettype none

module dp_hs_ack import dp_cfg_pkg::*, dp_cdc_pkg::*; #(
   parameter int data_width = data_width_default
) (
   input  logic                  async_reset_n,
   input  logic                  sync_reset_n,
   input  sync_depth_t           sync_ctrl,
   input  logic                  di_clk,
   input  logic                  ai_req_n,
   output logic                  ai_ack_n,
   input  logic [data_width-1:0] hold_data,
   output logic                  di_valid,
   output logic [data_width-1:0] di_data,
   input  logic                  di_take
);

   ack_state_t state_q;
   ack_state_t next_state;
   logic       next_ai_ack_n;
   logic       sync_req_n;
   logic       capture;

   // Request level into di_clk, idles high
   dp_sync #(
      .dp_width (1),
      .dp_reset (1'b1)
   ) req_sync_i (
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .clk           (di_clk),
      .sync_ctrl     (sync_ctrl),
      .d             (ai_req_n),
      .o             (sync_req_n)
   );

   always_ff @(posedge di_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         state_q  <= wait_req;
         ai_ack_n <= 1'b1;
      end else if (!sync_reset_n) begin
         state_q  <= wait_req;
         ai_ack_n <= 1'b1;
      end else begin
         state_q  <= next_state;
         ai_ack_n <= next_ai_ack_n;
      end
   end

   // Word register, hold_data is stable once the request is seen
   always_ff @(posedge di_clk) begin
      if (capture) di_data <= hold_data;
   end

   always_comb begin
      next_state    = state_q;
      next_ai_ack_n = ai_ack_n;
      capture       = 1'b0;
      case (state_q)
         wait_req: begin
            if (!sync_req_n) begin
               next_state = offer;
               capture    = 1'b1;
            end
         end
         offer: begin
            // Ack only after the consumer has the word
            if (di_take) begin
               next_state    = wait_req_deassert;
               next_ai_ack_n = 1'b0;
            end
         end
         wait_req_deassert: begin
            // Release the ack once the request is gone
            if (sync_req_n) begin
               next_state    = wait_req;
               next_ai_ack_n = 1'b1;
            end
         end
         default: begin
            next_state    = wait_req;
            next_ai_ack_n = 1'b1;
         end
      endcase
   end

   // Valid for exactly the offer phase
   assign di_valid = (state_q == offer);

   // Stalled word holds until taken
   a_data_hold: assert property (
      @(posedge di_clk) disable iff (!async_reset_n || !sync_reset_n)
      (di_valid && !di_take) |=> (di_valid && $stable(di_data))
   ) else $error("di_data changed during a stall");

endmodule : dp_hs_ack

`default_nettype wire

// ==== dp_hs/dp_hs_req.sv ====
/*
 * Request side of the four-phase handshake
 * Turns a held source request into a crossing level on ai_req_n
 * and answers the source with a one-cycle si_ack_n pulse
 */

`timescale 1ns/1ps
`default_nettype none

module dp_hs_req import dp_cfg_pkg::*, dp_cdc_pkg::*; (
   input  logic        async_reset_n,
   input  logic        sync_reset_n,
   input  sync_depth_t sync_ctrl,
   input  logic        si_clk,
   input  logic        si_req_n,
   output logic        si_ack_n,
   output logic        ai_req_n,
   input  logic        ai_ack_n
);

   req_state_t state_q;
   req_state_t next_state;
   logic       next_ai_req_n;
   logic       next_si_ack_n;
   logic       sync_ack_n;

   // Bring the destination ack into si_clk, idles high
   dp_sync #(
      .dp_width (1),
      .dp_reset (1'b1)
   ) ack_sync_i (
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .clk           (si_clk),
      .sync_ctrl     (sync_ctrl),
      .d             (ai_ack_n),
      .o             (sync_ack_n)
   );

   // State and registered outputs
   always_ff @(posedge si_clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         state_q  <= wait_req_assert;
         ai_req_n <= 1'b1;
         si_ack_n <= 1'b1;
      end else if (!sync_reset_n) begin
         state_q  <= wait_req_assert;
         ai_req_n <= 1'b1;
         si_ack_n <= 1'b1;
      end else begin
         state_q  <= next_state;
         ai_req_n <= next_ai_req_n;
         si_ack_n <= next_si_ack_n;
      end
   end

   // Next state decode
   always_comb begin
      // Outputs idle high unless a state says otherwise
      next_state    = state_q;
      next_ai_req_n = 1'b1;
      next_si_ack_n = 1'b1;
      case (state_q)
         wait_req_assert: begin
            // Source request launches the crossing level
            if (!si_req_n) begin
               next_state    = wait_ack_assert;
               next_ai_req_n = 1'b0;
            end
         end
         wait_ack_assert: begin
            if (!sync_ack_n) begin
               // Ack seen: drop the request, pulse the source once
               next_state    = wait_ack_deassert;
               next_si_ack_n = 1'b0;
            end else begin
               next_ai_req_n = 1'b0;
            end
         end
         wait_ack_deassert: begin
            // Last phase, far side releases its ack
            if (sync_ack_n) next_state = wait_req_assert;
         end
         default: next_state = wait_req_assert;
      endcase
   end

   // Source sees one acknowledge per transfer
   a_ack_single: assert property (
      @(posedge si_clk) disable iff (!async_reset_n)
      !si_ack_n |=> si_ack_n
   ) else $error("si_ack_n low for more than one cycle");

endmodule : dp_hs_req

`default_nettype wire

// ==== rtl/dp_sync.sv ====
/*
 * Multi-stage level synchronizer
 * Four flop stages, output tapped at stage two, three or four by sync_ctrl
 */

`timescale 1ns/1ps
`default_nettype none

module dp_sync import dp_cfg_pkg::*; #(
   parameter int                  dp_width = 1,
   parameter logic [dp_width-1:0] dp_reset = '0
) (
   input  logic                async_reset_n,
   input  logic                sync_reset_n,
   input  logic                clk,
   input  sync_depth_t         sync_ctrl,
   input  logic [dp_width-1:0] d,
   output logic [dp_width-1:0] o
);

   // Stage 0 samples the asynchronous input
   logic [dp_width-1:0] stage_q [4];

   always_ff @(posedge clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         for (int i = 0; i < 4; i++) stage_q[i] <= dp_reset;
      end else if (!sync_reset_n) begin
         for (int i = 0; i < 4; i++) stage_q[i] <= dp_reset;
      end else begin
         stage_q[0] <= d;
         // Shift toward the last stage
         for (int i = 1; i < 4; i++) stage_q[i] <= stage_q[i-1];
      end
   end

   // Depth select, unused code falls back to four stages
   always_comb begin
      case (sync_ctrl)
         sync_2:  o = stage_q[1];
         sync_3:  o = stage_q[2];
         default: o = stage_q[3];
      endcase
   end

endmodule : dp_sync

`default_nettype wire

// ==== common/dp_cdc_pkg.sv ====
/*
 * Protocol package for the four-phase handshake
 * State encodings of the source, request and acknowledge machines
 */

`default_nettype none

package dp_cdc_pkg;

   // Request side, crossing toward the destination
   typedef enum logic [1:0] {
      wait_req_assert   = 2'd0,
      wait_ack_assert   = 2'd1,
      wait_ack_deassert = 2'd2
   } req_state_t;

   // Acknowledge side, destination domain
   typedef enum logic [1:0] {
      wait_req          = 2'd0,
      offer             = 2'd1,
      wait_req_deassert = 2'd2
   } ack_state_t;

   // Source front end
   typedef enum logic {
      idle = 1'b0,
      busy = 1'b1
   } src_state_t;

endpackage : dp_cdc_pkg

`default_nettype wire

// ==== common/dp_cfg_pkg.sv ====
/*
 * Configuration package for the CDC port
 * Default word width and the synchronizer depth encoding
 */

`default_nettype none

package dp_cfg_pkg;

   // Width of one transferred word unless the top level overrides it
   parameter int data_width_default = 32;

   // Synchronizer depth select
   // Code 2'd3 is not named and is decoded like sync_4
   typedef enum logic [1:0] {
      sync_2 = 2'd0,   // two flop stages
      sync_3 = 2'd1,   // three flop stages
      sync_4 = 2'd2    // four flop stages
   } sync_depth_t;

endpackage : dp_cfg_pkg

`default_nettype wire
